// File: Bender.yml
package:
  name: stats_updater

sources:
  - logic/stats_pkg.sv
  - logic/record_queue.sv
  - logic/slot_update.sv
  - logic/rmw_ctrl.sv
  - logic/stats_top.sv
  - target: test
    files:
      - dv/stats_assertions.sv
      - dv/stats_tb.sv

// File: build.f
logic/stats_pkg.sv
logic/record_queue.sv
logic/slot_update.sv
logic/rmw_ctrl.sv
logic/stats_top.sv
dv/stats_assertions.sv
dv/stats_tb.sv

// File: dv/stats_assertions.sv
`timescale 1ns/10ps

module stats_assertions
(
	input logic                    clk,
	input logic                    reset,
	input logic                    rec_valid,
	input stats_pkg::stat_record_t rec,
	input logic                    mem_busy,
	input logic                    mem_rd_en,
	input logic                    mem_wr_en,
	input logic                    mem_rd_valid
);

	logic rd_open;	// read issued, data not back yet
	int   fail_count = 0;	// failed assertions so far

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_open <= 1'b0;
		else if (mem_rd_en)
			rd_open <= 1'b1;
		else if (mem_rd_valid)
			rd_open <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM port protocol
	////////////////////////////////////////////////////////////////////////////

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_rd_en && mem_wr_en))
		else
		begin
			$error("read and write requested in the same cycle");
			fail_count++;
		end

	no_req_when_busy: assert property (@(posedge clk) disable iff (reset)
		mem_busy |-> !(mem_rd_en || mem_wr_en))
		else
		begin
			$error("request issued while mem_busy was high");
			fail_count++;
		end

	one_read_open: assert property (@(posedge clk) disable iff (reset)
		mem_rd_en |-> !rd_open)
		else
		begin
			$error("read issued while another read was outstanding");
			fail_count++;
		end

	// zero id would look like an empty slot
	record_id_set: assert property (@(posedge clk) disable iff (reset)
		rec_valid |-> (rec.flow_id != '0))
		else
		begin
			$error("record entered with a zero flow id");
			fail_count++;
		end

endmodule

bind stats_top stats_assertions u_assertions (.*);

// File: dv/stats_tb.sv
`timescale 1ns/10ps

module stats_tb;
	import stats_pkg::*;

	localparam int SEND_LIMIT  = 20000;	// cycles, covers the clear pass
	localparam int DRAIN_LIMIT = 5000;

	// one expected slot from the trace
	typedef struct packed
	{
		logic [STAT_ADDR_W-1:0] addr;
		logic                   slot;
		logic [FLOW_ID_W-1:0]   flow_id;
		logic [PKT_CNT_W-1:0]   pkt_cnt;
		logic [BYTE_CNT_W-1:0]  byte_cnt;
	} expect_t;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   cal_done;
	logic                   rec_valid;
	stat_record_t           rec;
	logic                   credit_return;
	logic                   mem_busy = 1'b0;
	logic                   mem_rd_en;
	logic                   mem_wr_en;
	logic [STAT_ADDR_W-1:0] mem_addr;
	mem_word_u              mem_wdata;
	logic                   mem_rd_valid = 1'b0;
	mem_word_u              mem_rdata = '0;
	logic [DROP_CNT_W-1:0]  drop_cnt;

	logic [MEM_WORD_W-1:0]  sram [STAT_WORDS];	// counter SRAM model
	logic [31:0]            lfsr = 32'h44fb1103;
	stat_record_t           records [$];
	expect_t                expects [$];
	int                     exp_drops = 0;
	int                     sent = 0;	// records driven
	int                     returned = 0;	// credit_return pulses seen
	int                     clear_cnt = 0;
	int                     rec_wr_cnt = 0;
	int                     rd_cnt = 0;
	int                     rd_seen = 0;
	int                     rd_wait = 0;
	logic [STAT_ADDR_W-1:0] rd_addr = '0;
	int                     checks = 0;
	int                     check_errors = 0;
	int                     monitor_errors = 0;
	int                     assert_errors = 0;
	bit                     timed_out = 1'b0;

	stats_top dut
	(
		.clk           (clk),
		.reset         (reset),
		.cal_done      (cal_done),
		.rec_valid     (rec_valid),
		.rec           (rec),
		.credit_return (credit_return),
		.mem_busy      (mem_busy),
		.mem_rd_en     (mem_rd_en),
		.mem_wr_en     (mem_wr_en),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_rd_valid  (mem_rd_valid),
		.mem_rdata     (mem_rdata),
		.drop_cnt      (drop_cnt)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// one LFSR step per bit
	function automatic int unsigned draw_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v    = (v << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// nonzero garbage built from the whole address
	function automatic logic [26:0] fill_pattern(input int a);
		logic [STAT_ADDR_W-1:0] a11;
		a11 = STAT_ADDR_W'(a);
		return {5'h15, a11 ^ 11'h5a5, a11};
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (expected === actual)
		else
		begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			check_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// trace reader
	////////////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		int           fd;
		int           got;
		string        line;
		logic [63:0]  f0, f1, f2, f3, f4;
		expect_t      e;
		stat_record_t r;
		fd = $fopen("dv/stats_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file dv/stats_trace.txt");
			check_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			got  = $fgets(line, fd);
			if (got == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			if (line.getc(0) == "R")
			begin
				got = $sscanf(line, "R %h %h %h", f0, f1, f2);
				r.addr    = f0[10:0];
				r.flow_id = f1[15:0];
				r.len     = f2[15:0];
				records.push_back(r);
			end
			else if (line.getc(0) == "E")
			begin
				got = $sscanf(line, "E %h %h %h %h %h", f0, f1, f2, f3, f4);
				e = '{f0[10:0], f1[0], f2[15:0], f3[31:0], f4[59:0]};
				expects.push_back(e);
				got = (got == 5) ? 3 : 0;	// same count as a record line
			end
			else
			begin
				got = $sscanf(line, "D %h", f0);
				exp_drops = int'(f0);
				got = (got == 1) ? 3 : 0;
			end
			if (got != 3)
			begin
				$display("trace line not understood: %s", line);
				check_errors++;
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// SRAM model
	////////////////////////////////////////////////////////////////////////////

	// requests sampled on the rising edge
	always @(posedge clk)
	begin
		int credit_now;
		if (reset)
		begin
			for (int a = 0; a < STAT_WORDS; a++)
				sram[a] = {8{fill_pattern(a)}};
		end
		else
		begin
			if (credit_return)
				returned++;
			credit_now = QUEUE_DEPTH - sent + returned;
			assert (credit_now >= 0 && credit_now <= QUEUE_DEPTH)
			else
			begin
				$display("credit counter left its range, now %0d", credit_now);
				monitor_errors++;
			end
			if (mem_wr_en)
			begin
				if (clear_cnt < STAT_WORDS)
				begin
					assert (mem_addr == STAT_ADDR_W'(clear_cnt))
					else
					begin
						$display("FAIL clear_addr expected %0h actual %0h", clear_cnt, mem_addr);
						monitor_errors++;
					end
					assert (mem_wdata.raw == '0)
					else
					begin
						$display("FAIL clear_data expected 0 actual %0h", mem_wdata.raw);
						monitor_errors++;
					end
					clear_cnt++;
				end
				else
				begin
					assert (rd_cnt == rec_wr_cnt + 1)
					else
					begin
						$display("record write at %0h without a matching read", mem_addr);
						monitor_errors++;
					end
					rec_wr_cnt++;
				end
				sram[mem_addr] = mem_wdata.raw;
			end
			if (mem_rd_en)
			begin
				assert (clear_cnt == STAT_WORDS)
				else
				begin
					$display("read issued before clearing had finished");
					monitor_errors++;
				end
				rd_addr = mem_addr;
				rd_cnt++;
			end
		end
	end

	// busy and read data driven on the falling edge
	always @(negedge clk)
	begin
		mem_busy     = (draw_bits(2) == 0);	// about one cycle in four
		mem_rd_valid = 1'b0;
		if (rd_seen != rd_cnt)
		begin
			rd_seen = rd_cnt;
			rd_wait = draw_bits(2) + 1;	// 1 to 4 cycles
		end
		if (rd_wait != 0)
		begin
			rd_wait--;
			if (rd_wait == 0)
			begin
				mem_rd_valid  = 1'b1;
				mem_rdata.raw = sram[rd_addr];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic send_records();
		int idx;
		int cycles;
		idx    = 0;
		cycles = 0;
		while (idx < records.size() && !timed_out)
		begin
			@(negedge clk);
			if (sent - returned < QUEUE_DEPTH)
			begin
				rec_valid = 1'b1;
				rec       = records[idx];
				idx++;
				sent++;
			end
			else
				rec_valid = 1'b0;	// out of credit
			cycles++;
			if (cycles > SEND_LIMIT)
			begin
				$display("timed out sending records, %0d of %0d sent", idx, records.size());
				check_errors++;
				timed_out = 1'b1;
			end
		end
		@(negedge clk);
		rec_valid = 1'b0;
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while ((rec_wr_cnt < records.size() || returned < sent) && !timed_out)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > DRAIN_LIMIT)
			begin
				$display("timed out waiting for record writes, %0d of %0d seen",
					rec_wr_cnt, records.size());
				check_errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic check_results();
		mem_word_u w;
		string     name;
		foreach (expects[i])
		begin
			w.raw = sram[expects[i].addr];
			name  = $sformatf("word %0h slot %0d", expects[i].addr, expects[i].slot);
			compare_value({name, " flow_id"}, expects[i].flow_id,
				w.slot[expects[i].slot].flow_id);
			compare_value({name, " pkt_cnt"}, expects[i].pkt_cnt,
				w.slot[expects[i].slot].pkt_cnt);
			compare_value({name, " byte_cnt"}, expects[i].byte_cnt,
				w.slot[expects[i].slot].byte_cnt);
		end
		compare_value("drop_cnt", exp_drops, drop_cnt);
		compare_value("record_writes", records.size(), rec_wr_cnt);
		compare_value("credit_returns", records.size(), returned);
		compare_value("final_credits", QUEUE_DEPTH, QUEUE_DEPTH - sent + returned);
	endtask

	initial
	begin
		reset     = 1'b1;
		cal_done  = 1'b0;
		rec_valid = 1'b0;
		rec       = '0;
		load_trace();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		cal_done = 1'b1;
		send_records();
		if (!timed_out)
			wait_for_drain();
		if (!timed_out)
			check_results();
		assert_errors = dut.u_assertions.fail_count;
		$display("checks %0d, failed checks %0d, monitor errors %0d, assertion failures %0d",
			checks, check_errors, monitor_errors, assert_errors);
		if (check_errors + monitor_errors + assert_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: dv/stats_trace.txt
# R addr flow_id len                    record, all fields hex
# E addr slot flow_id pkt_cnt byte_cnt  expected final slot, D drops  expected drop_cnt
R 005 0101 0040
R 123 0a0a 0100
R 005 0101 0020
R 123 0b0b 0080
R 7ff ffff ffff
R 123 0c0c 0055
R 005 0101 0010
R 000 0001 0001
R 400 2222 0010
R 123 0a0a 0100
R 400 3333 0020
R 7ff ffff ffff
R 400 4444 0030
R 123 0b0b 0008
R 400 3333 0020
R 123 0c0c 0001
R 005 0101 0005
# single flow accumulating in slot 0
E 005 0 0101 00000004 75
E 005 1 0000 00000000 0
# both slots taken, third flow dropped twice
E 123 0 0a0a 00000002 200
E 123 1 0b0b 00000002 88
# byte count carries past the record length width
E 7ff 0 ffff 00000002 1fffe
E 7ff 1 0000 00000000 0
E 000 0 0001 00000001 1
E 000 1 0000 00000000 0
E 400 0 2222 00000001 10
E 400 1 3333 00000002 40
# untouched word, cleared from garbage
E 001 0 0000 00000000 0
E 001 1 0000 00000000 0
D 3

// File: logic/record_queue.sv
`timescale 1ns/10ps

module record_queue
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rec_valid,
	input  stats_pkg::stat_record_t rec,
	input  logic                    q_pop,
	output logic                    q_valid,
	output stats_pkg::stat_record_t q_rec,
	output logic                    credit_return
);
	import stats_pkg::*;

	stat_record_t      rec_mem [QUEUE_DEPTH];	// record storage
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;	// records held

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			if (rec_valid)
			begin
				if (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (q_pop)
			begin
				if (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			count         <= count + QCNT_W'(rec_valid) - QCNT_W'(q_pop);
			credit_return <= q_pop;	// one credit back per record handed on
		end
	end

	// source never pushes without credit, so no full check here
	always_ff @(posedge clk)
	begin
		if (rec_valid)
			rec_mem[wr_ptr] <= rec;
	end

	assign q_valid = (count != '0);
	assign q_rec   = rec_mem[rd_ptr];	// head of queue

endmodule

// File: logic/rmw_ctrl.sv
`timescale 1ns/10ps

module rmw_ctrl
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 cal_done,
	input  logic                                 q_valid,
	input  stats_pkg::stat_record_t              q_rec,
	input  logic                                 mem_busy,
	input  logic                                 mem_rd_valid,
	input  stats_pkg::mem_word_u                 mem_rdata,
	input  stats_pkg::mem_word_u                 new_word,
	input  logic                                 hit,
	output logic                                 q_pop,
	output stats_pkg::stat_record_t              cur_rec,
	output logic                                 mem_rd_en,
	output logic                                 mem_wr_en,
	output logic [stats_pkg::STAT_ADDR_W-1:0]    mem_addr,
	output stats_pkg::mem_word_u                 mem_wdata,
	output logic [stats_pkg::DROP_CNT_W-1:0]     drop_cnt
);
	import stats_pkg::*;

	typedef enum logic [2:0]
	{
		ST_IDLE,	// waiting for calibration
		ST_CLEAR,	// zeroing counter memory
		ST_WAIT,	// ready for a record
		ST_READ,	// read request pending
		ST_AWAIT,	// read issued and data not back yet
		ST_WRITE	// merged word pending
	} state_t;

	state_t                 state;
	logic [STAT_ADDR_W-1:0] clear_addr;
	mem_word_u              wr_word;	// word to write back
	logic                   rd_go;
	logic                   wr_go;

	assign q_pop = (state == ST_WAIT) && q_valid;
	assign rd_go = (state == ST_READ) && !mem_busy;
	assign wr_go = ((state == ST_CLEAR) || (state == ST_WRITE)) && !mem_busy;

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= ST_IDLE;
			clear_addr <= '0;
			drop_cnt   <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					clear_addr <= '0;
					if (cal_done)
						state <= ST_CLEAR;
				end
				ST_CLEAR:
				begin
					if (wr_go)
					begin
						if (clear_addr == STAT_ADDR_W'(STAT_WORDS - 1))
							state <= ST_WAIT;	// last word zeroed
						else
							clear_addr <= clear_addr + 1'b1;
					end
				end
				ST_WAIT:
				begin
					if (q_pop)
						state <= ST_READ;
				end
				ST_READ:
				begin
					if (rd_go)
						state <= ST_AWAIT;
				end
				ST_AWAIT:
				begin
					if (mem_rd_valid)
					begin
						state <= ST_WRITE;
						if (!hit && (drop_cnt != '1))
							drop_cnt <= drop_cnt + 1'b1;	// no slot free, saturating
					end
				end
				ST_WRITE:
				begin
					if (wr_go)
						state <= ST_WAIT;
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// record and merged word
	always_ff @(posedge clk)
	begin
		if (q_pop)
			cur_rec <= q_rec;
		if ((state == ST_AWAIT) && mem_rd_valid)
			wr_word <= new_word;	// a drop comes back as read
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM request port
	////////////////////////////////////////////////////////////////////////////

	assign mem_rd_en = rd_go;
	assign mem_wr_en = wr_go;

	always_comb
	begin
		if ((state == ST_READ) || (state == ST_WRITE))
			mem_addr = cur_rec.addr;
		else
			mem_addr = clear_addr;
	end

	always_comb
	begin
		if (state == ST_CLEAR)
			mem_wdata.raw = '0;	// zero fill
		else
			mem_wdata = wr_word;
	end

endmodule

// File: logic/slot_update.sv
`timescale 1ns/10ps

module slot_update
(
	input  stats_pkg::stat_record_t rec,
	input  stats_pkg::mem_word_u    old_word,
	output stats_pkg::mem_word_u    new_word,
	output logic                    hit
);
	import stats_pkg::*;

	logic [BYTE_CNT_W-1:0]      len_ext;	// record length widened to the byte count
	stat_slot_t                 claim_slot;	// contents for a fresh slot
	logic [NUM_SLOTS-1:0]       slot_empty;
	logic [NUM_SLOTS-1:0]       slot_match;
	stat_slot_t [NUM_SLOTS-1:0] bumped;	// each slot with this record added

	assign len_ext = {{(BYTE_CNT_W - LEN_W){1'b0}}, rec.len};

	assign claim_slot = '{
		flow_id:  rec.flow_id,
		pkt_cnt:  PKT_CNT_W'(1),
		byte_cnt: len_ext
	};

	////////////////////////////////////////////////////////////////////////////
	// per-slot compare and add
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			slot_empty[i]      = (old_word.slot[i].flow_id == '0);
			slot_match[i]      = (old_word.slot[i].flow_id == rec.flow_id);
			bumped[i]          = old_word.slot[i];
			bumped[i].pkt_cnt  = old_word.slot[i].pkt_cnt + 1'b1;
			bumped[i].byte_cnt = old_word.slot[i].byte_cnt + len_ext;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// priority pick
	////////////////////////////////////////////////////////////////////////////

	// walks slot 0 then slot 1, empty checked before match in each
	// first case that applies wins, the other slot stays as read
	always_comb
	begin
		new_word = old_word;
		hit      = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			if (!hit && slot_empty[i])
			begin
				new_word.slot[i] = claim_slot;	// claim free slot
				hit              = 1'b1;
			end
			else if (!hit && slot_match[i])
			begin
				new_word.slot[i] = bumped[i];	// same flow
				hit              = 1'b1;
			end
		end
	end

endmodule

// File: logic/stats_pkg.sv
package stats_pkg;

	////////////////////////////////////////////////////////////////////////////
	// counter memory geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int STAT_ADDR_W = 11;	// word address into counter SRAM
	localparam int STAT_WORDS  = 2048;	// words zeroed after calibration
	localparam int MEM_WORD_W  = 216;	// SRAM data width
	localparam int NUM_SLOTS   = 2;	// counter slots per memory word

	////////////////////////////////////////////////////////////////////////////
	// counter fields
	////////////////////////////////////////////////////////////////////////////

	localparam int FLOW_ID_W  = 16;	// zero marks an empty slot
	localparam int PKT_CNT_W  = 32;
	localparam int BYTE_CNT_W = 60;
	localparam int LEN_W      = 16;	// byte length carried by a record
	localparam int DROP_CNT_W = 16;	// saturating drop counter

	////////////////////////////////////////////////////////////////////////////
	// record queue
	////////////////////////////////////////////////////////////////////////////

	localparam int QUEUE_DEPTH = 4;	// also the credits held after reset
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);	// holds 0 to QUEUE_DEPTH

	// one packet record from the source
	typedef struct packed
	{
		logic [STAT_ADDR_W-1:0] addr;
		logic [FLOW_ID_W-1:0]   flow_id;
		logic [LEN_W-1:0]       len;
	} stat_record_t;

	// one counter slot, 108 bits
	typedef struct packed
	{
		logic [FLOW_ID_W-1:0]  flow_id;
		logic [PKT_CNT_W-1:0]  pkt_cnt;
		logic [BYTE_CNT_W-1:0] byte_cnt;
	} stat_slot_t;

	// memory word seen as pin bits or as two slots
	// slot[1] sits in the upper half
	typedef union packed
	{
		logic [MEM_WORD_W-1:0]       raw;	// clearing and SRAM pins
		stat_slot_t [NUM_SLOTS-1:0] slot;	// merge view
	} mem_word_u;

endpackage

// File: logic/stats_top.sv
`timescale 1ns/10ps

module stats_top
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cal_done,
	input  logic                              rec_valid,
	input  stats_pkg::stat_record_t           rec,
	output logic                              credit_return,
	input  logic                              mem_busy,
	output logic                              mem_rd_en,
	output logic                              mem_wr_en,
	output logic [stats_pkg::STAT_ADDR_W-1:0] mem_addr,
	output stats_pkg::mem_word_u              mem_wdata,
	input  logic                              mem_rd_valid,
	input  stats_pkg::mem_word_u              mem_rdata,
	output logic [stats_pkg::DROP_CNT_W-1:0]  drop_cnt
);
	import stats_pkg::*;

	logic         q_valid;
	stat_record_t q_rec;
	logic         q_pop;
	stat_record_t cur_rec;	// record in flight
	mem_word_u    new_word;
	logic         hit;

	////////////////////////////////////////////////////////////////////////////
	// record path
	////////////////////////////////////////////////////////////////////////////

	record_queue u_queue
	(
		.clk           (clk),
		.reset         (reset),
		.rec_valid     (rec_valid),
		.rec           (rec),
		.q_pop         (q_pop),
		.q_valid       (q_valid),
		.q_rec         (q_rec),
		.credit_return (credit_return)
	);

	rmw_ctrl u_ctrl
	(
		.clk          (clk),
		.reset        (reset),
		.cal_done     (cal_done),
		.q_valid      (q_valid),
		.q_rec        (q_rec),
		.mem_busy     (mem_busy),
		.mem_rd_valid (mem_rd_valid),
		.mem_rdata    (mem_rdata),
		.new_word     (new_word),
		.hit          (hit),
		.q_pop        (q_pop),
		.cur_rec      (cur_rec),
		.mem_rd_en    (mem_rd_en),
		.mem_wr_en    (mem_wr_en),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.drop_cnt     (drop_cnt)
	);

	// merge works straight off the read data bus
	slot_update u_merge
	(
		.rec      (cur_rec),
		.old_word (mem_rdata),
		.new_word (new_word),
		.hit      (hit)
	);

endmodule
